//--- hdl/alu32.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_display_settings.svh"

module alu32 (
   input  logic                  clk,
   input  logic                  resetn,
   alu_req_if.exec               req,
   output logic [`ALU_WIDTH-1:0] result,
   output logic                  cout
);

   // shift amount width, 5 bits for 32
   localparam int SHAMT_WIDTH = $clog2(`ALU_WIDTH);

   // adder with carry out on top
   logic [`ALU_WIDTH:0]     add_full;
   // plain difference
   logic [`ALU_WIDTH-1:0]   sub_res;
   // no borrow flag
   logic                    sub_nb;
   // signed less than
   logic                    slt_flag;
   // barrel shift
   logic [`ALU_WIDTH-1:0]   sll_res;
   logic [SHAMT_WIDTH-1:0]  shamt;

   // next result and carry before the register
   logic [`ALU_WIDTH-1:0]   nxt_result;
   logic                    nxt_cout;

   //************************************************************
   // datapath units
   //************************************************************

   // one bit wider so the carry out of the msb is kept
   assign add_full = {1'b0, req.in1} + {1'b0, req.in2} + {{`ALU_WIDTH{1'b0}}, req.cin};

   // cin not used here
   assign sub_res = req.in1 - req.in2;
   assign sub_nb  = (req.in1 >= req.in2);

   assign slt_flag = ($signed(req.in1) < $signed(req.in2));

   // only the low bits of in2 count
   assign shamt   = req.in2[SHAMT_WIDTH-1:0];
   assign sll_res = req.in1 << shamt;

   //************************************************************
   // opcode select
   //************************************************************

   always_comb
   begin
      // logic ops and compares leave carry low
      nxt_cout = 1'b0;
      case (req.op)
         alu_display_pkg::OP_ADD:
         begin
            nxt_result = add_full[`ALU_WIDTH-1:0];
            nxt_cout   = add_full[`ALU_WIDTH];
         end
         alu_display_pkg::OP_SUB:
         begin
            nxt_result = sub_res;
            nxt_cout   = sub_nb;
         end
         alu_display_pkg::OP_AND: nxt_result = req.in1 & req.in2;
         alu_display_pkg::OP_OR:  nxt_result = req.in1 | req.in2;
         alu_display_pkg::OP_XOR: nxt_result = req.in1 ^ req.in2;
         alu_display_pkg::OP_NOR: nxt_result = ~(req.in1 | req.in2);
         // zero extended flag
         alu_display_pkg::OP_SLT: nxt_result = {{(`ALU_WIDTH-1){1'b0}}, slt_flag};
         alu_display_pkg::OP_SLL: nxt_result = sll_res;
         default:                 nxt_result = '0;
      endcase
   end

   // result lags operands by one cycle
   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         result <= '0;
         cout   <= 1'b0;
      end
      else
      begin
         result <= nxt_result;
         cout   <= nxt_cout;
      end
   end

endmodule

`default_nettype wire

//--- hdl/alu_display.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_display_settings.svh"

module alu_display (
   input  logic                   clk,
   input  logic                   resetn,

   // select switches and carry switch
   input  logic [`SEL_WIDTH-1:0]  input_sel,
   input  logic                   sw_cin,

   // typed number from the panel
   input  logic                   input_valid,
   input  logic [`ALU_WIDTH-1:0]  input_value,

   // slot poll and answer
   input  logic [`SLOT_WIDTH-1:0] display_number,
   output logic                   display_valid,
   output logic [`NAME_WIDTH-1:0] display_name,
   output logic [`ALU_WIDTH-1:0]  display_value,

   // carry out led
   output logic                   led_cout
);

   // switch value as the select enum
   alu_display_pkg::input_sel_e sel;

   // registered alu outputs
   logic [`ALU_WIDTH-1:0] alu_result;
   logic                  alu_cout;

   //************************************************************
   // operand bundle
   //************************************************************

   alu_req_if req_bus ();

   assign sel = alu_display_pkg::input_sel_e'(input_sel);

   //************************************************************
   // decode, execute, display
   //************************************************************

   operand_capture u_capture (
      .clk         (clk),
      .resetn      (resetn),
      .input_valid (input_valid),
      .input_value (input_value),
      .input_sel   (sel),
      .sw_cin      (sw_cin),
      .req         (req_bus.capture)
   );

   alu32 u_alu (
      .clk    (clk),
      .resetn (resetn),
      .req    (req_bus.exec),
      .result (alu_result),
      .cout   (alu_cout)
   );

   display_mux u_display (
      .clk            (clk),
      .resetn         (resetn),
      .req            (req_bus.monitor),
      .result         (alu_result),
      .cout           (alu_cout),
      .display_number (display_number),
      .display_valid  (display_valid),
      .display_name   (display_name),
      .display_value  (display_value)
   );

   // led shows the registered carry
   assign led_cout = alu_cout;

endmodule

`default_nettype wire

//--- hdl/alu_display_pkg.sv
`default_nettype none

`include "alu_display_settings.svh"

package alu_display_pkg;

   //************************************************************
   // alu opcodes
   //************************************************************

   // loaded straight from the low bits of the typed value
   typedef enum logic [`OP_WIDTH-1:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_OR  = 3'd3,
      OP_XOR = 3'd4,
      OP_NOR = 3'd5,
      OP_SLT = 3'd6,
      OP_SLL = 3'd7
   } alu_op_e;

   //************************************************************
   // input select switches
   //************************************************************

   // value 3 has no target register
   typedef enum logic [`SEL_WIDTH-1:0] {
      SEL_OPER1  = 2'd0,
      SEL_OPER2  = 2'd1,
      SEL_OPCODE = 2'd2
   } input_sel_e;

endpackage

`default_nettype wire

//--- hdl/alu_req_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_display_settings.svh"

// operand bundle from capture to execute and display
interface alu_req_if;

   // captured operands
   logic [`ALU_WIDTH-1:0] in1;
   logic [`ALU_WIDTH-1:0] in2;

   // captured opcode
   alu_display_pkg::alu_op_e op;

   // carry switch, not registered
   logic cin;

   // operand capture side
   modport capture (output in1, output in2, output op, output cin);

   // alu side
   modport exec (input in1, input in2, input op, input cin);

   // display side, read only
   modport monitor (input in1, input in2, input op, input cin);

endinterface

`default_nettype wire

//--- hdl/display_mux.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_display_settings.svh"

module display_mux (
   input  logic                   clk,
   input  logic                   resetn,
   alu_req_if.monitor             req,
   input  logic [`ALU_WIDTH-1:0]  result,
   input  logic                   cout,
   input  logic [`SLOT_WIDTH-1:0] display_number,
   output logic                   display_valid,
   output logic [`NAME_WIDTH-1:0] display_name,
   output logic [`ALU_WIDTH-1:0]  display_value
);

   // slot numbers the panel polls
   localparam logic [`SLOT_WIDTH-1:0] SLOT_IN1 = 1;
   localparam logic [`SLOT_WIDTH-1:0] SLOT_IN2 = 2;
   localparam logic [`SLOT_WIDTH-1:0] SLOT_OP  = 3;
   localparam logic [`SLOT_WIDTH-1:0] SLOT_CI  = 4;
   localparam logic [`SLOT_WIDTH-1:0] SLOT_OUT = 5;
   localparam logic [`SLOT_WIDTH-1:0] SLOT_CO  = 6;

   // ascii names zero padded on the left
   localparam logic [`NAME_WIDTH-1:0] NAME_IN1 = "IN1";
   localparam logic [`NAME_WIDTH-1:0] NAME_IN2 = "IN2";
   localparam logic [`NAME_WIDTH-1:0] NAME_OP  = "OP";
   localparam logic [`NAME_WIDTH-1:0] NAME_CI  = "CI";
   localparam logic [`NAME_WIDTH-1:0] NAME_OUT = "OUT";
   localparam logic [`NAME_WIDTH-1:0] NAME_CO  = "CO";

   // decoded slot before the register
   logic                   nxt_valid;
   logic [`NAME_WIDTH-1:0] nxt_name;
   logic [`ALU_WIDTH-1:0]  nxt_value;

   //************************************************************
   // slot decode
   //************************************************************

   always_comb
   begin
      // unused slots read as all zero
      nxt_valid = 1'b1;
      nxt_name  = '0;
      nxt_value = '0;
      case (display_number)
         SLOT_IN1:
         begin
            nxt_name  = NAME_IN1;
            nxt_value = req.in1;
         end
         SLOT_IN2:
         begin
            nxt_name  = NAME_IN2;
            nxt_value = req.in2;
         end
         SLOT_OP:
         begin
            nxt_name  = NAME_OP;
            nxt_value = {{(`ALU_WIDTH-`OP_WIDTH){1'b0}}, req.op};
         end
         SLOT_CI:
         begin
            nxt_name  = NAME_CI;
            nxt_value = {{(`ALU_WIDTH-1){1'b0}}, req.cin};
         end
         SLOT_OUT:
         begin
            nxt_name  = NAME_OUT;
            nxt_value = result;
         end
         SLOT_CO:
         begin
            nxt_name  = NAME_CO;
            nxt_value = {{(`ALU_WIDTH-1){1'b0}}, cout};
         end
         default:  nxt_valid = 1'b0;
      endcase
   end

   // one cycle behind the polled number
   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         display_valid <= 1'b0;
         display_name  <= '0;
         display_value <= '0;
      end
      else
      begin
         display_valid <= nxt_valid;
         display_name  <= nxt_name;
         display_value <= nxt_value;
      end
   end

endmodule

`default_nettype wire

//--- hdl/operand_capture.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_display_settings.svh"

module operand_capture (
   input  logic                          clk,
   input  logic                          resetn,
   input  logic                          input_valid,
   input  logic [`ALU_WIDTH-1:0]         input_value,
   input  alu_display_pkg::input_sel_e   input_sel,
   input  logic                          sw_cin,
   alu_req_if.capture                    req
);

   // per register write enables
   logic wr_in1;
   logic wr_in2;
   logic wr_op;

   // opcode taken from the low bits of the typed value
   alu_display_pkg::alu_op_e new_op;

   //************************************************************
   // write decode
   //************************************************************

   // select 3 matches nothing, pulse dropped
   assign wr_in1 = input_valid && (input_sel == alu_display_pkg::SEL_OPER1);
   assign wr_in2 = input_valid && (input_sel == alu_display_pkg::SEL_OPER2);
   assign wr_op  = input_valid && (input_sel == alu_display_pkg::SEL_OPCODE);

   // upper bits of the value ignored for the opcode
   assign new_op = alu_display_pkg::alu_op_e'(input_value[`OP_WIDTH-1:0]);

   //************************************************************
   // operand registers
   //************************************************************

   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         req.in1 <= '0;
         req.in2 <= '0;
         req.op  <= alu_display_pkg::OP_ADD;
      end
      else
      begin
         // one edge after the pulse
         if (wr_in1)
            req.in1 <= input_value;
         if (wr_in2)
            req.in2 <= input_value;
         if (wr_op)
            req.op <= new_op;
      end
   end

   // carry switch passes straight through
   assign req.cin = sw_cin;

endmodule

`default_nettype wire

//--- include/alu_display_settings.svh
`ifndef ALU_DISPLAY_SETTINGS_SVH
`define ALU_DISPLAY_SETTINGS_SVH

// operand and result width
`define ALU_WIDTH 32

// slot name, five ascii characters
`define NAME_WIDTH 40

// slot number from the panel poll, slots 1 to 63
`define SLOT_WIDTH 6

// opcode field width
`define OP_WIDTH 3

// input select switches
`define SEL_WIDTH 2

`endif

//--- sim.f
+incdir+include
hdl/alu_display_pkg.sv
hdl/alu_req_if.sv
hdl/operand_capture.sv
hdl/alu32.sv
hdl/display_mux.sv
hdl/alu_display.sv
verif/tb_alu_display.sv

//--- verif/tb_alu_display.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_display_settings.svh"

module tb_alu_display;

   // run limit well above the roughly 1300 cycles the tests take
   localparam int TIMEOUT_CYCLES = 5000;

   logic                   clk;
   logic                   resetn;
   logic [`SEL_WIDTH-1:0]  input_sel;
   logic                   sw_cin;
   logic                   input_valid;
   logic [`ALU_WIDTH-1:0]  input_value;
   logic [`SLOT_WIDTH-1:0] display_number;
   logic                   display_valid;
   logic [`NAME_WIDTH-1:0] display_name;
   logic [`ALU_WIDTH-1:0]  display_value;
   logic                   led_cout;

   // outputs captured by the last poll
   logic                   polled_valid;
   logic [`NAME_WIDTH-1:0] polled_name;
   logic [`ALU_WIDTH-1:0]  polled_value;
   logic                   polled_led;

   int          error_count;
   int          cycle_count;
   logic [31:0] lcg_state;

   alu_display dut (
      .clk            (clk),
      .resetn         (resetn),
      .input_sel      (input_sel),
      .sw_cin         (sw_cin),
      .input_valid    (input_valid),
      .input_value    (input_value),
      .display_number (display_number),
      .display_valid  (display_valid),
      .display_name   (display_name),
      .display_value  (display_value),
      .led_cout       (led_cout)
   );

   // 20 ns clock
   initial
      clk = 1'b0;
   always #10 clk = ~clk;

   // run limit
   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   //************************************************************
   // helpers
   //************************************************************

   // lcg step with numerical recipes constants
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // reference alu with the carry on top of the result
   function automatic logic [32:0] alu_model(input logic [2:0] op, input logic [31:0] a,
                                             input logic [31:0] b, input logic c);
      logic [32:0] r;
      logic        lt;
      r  = '0;
      lt = 1'b0;
      case (op)
         3'd0: r = {1'b0, a} + {1'b0, b} + {32'd0, c};
         // no borrow flag on top and carry in unused
         3'd1: r = {(a >= b), a - b};
         3'd2: r = {1'b0, a & b};
         3'd3: r = {1'b0, a | b};
         3'd4: r = {1'b0, a ^ b};
         3'd5: r = {1'b0, ~(a | b)};
         3'd6:
         begin
            // when signs differ the negative one is smaller
            if (a[31] != b[31])
               lt = a[31];
            else
               lt = (a < b);
            r = {32'd0, lt};
         end
         3'd7: r = {1'b0, a << b[4:0]};
      endcase
      return r;
   endfunction

   // expected ascii name per slot
   function automatic logic [`NAME_WIDTH-1:0] slot_name(input int slot);
      case (slot)
         1: return "IN1";
         2: return "IN2";
         3: return "OP";
         4: return "CI";
         5: return "OUT";
         6: return "CO";
         default: return '0;
      endcase
   endfunction

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
         error_count++;
      end
   endtask

   // called and returns at a falling edge
   task automatic load(input logic [1:0] sel, input logic [31:0] value);
      input_sel   = sel;
      input_value = value;
      input_valid = 1'b1;
      @(posedge clk);
      @(negedge clk);
      input_valid = 1'b0;
   endtask

   // one idle cycle so the alu register catches up
   task automatic settle();
      @(posedge clk);
      @(negedge clk);
   endtask

   // outputs stable by the falling edge
   task automatic poll(input int slot);
      display_number = slot[`SLOT_WIDTH-1:0];
      @(posedge clk);
      @(negedge clk);
      polled_valid = display_valid;
      polled_name  = display_name;
      polled_value = display_value;
      polled_led   = led_cout;
   endtask

   // load operands and opcode then read slots 5 and 6
   task automatic run_operation(input logic [2:0] op, input logic [31:0] a,
                                input logic [31:0] b);
      logic [32:0] exp;
      load(2'd0, a);
      load(2'd1, b);
      load(2'd2, {29'd0, op});
      settle();
      exp = alu_model(op, a, b, sw_cin);
      poll(5);
      check("slot 5 value", polled_value, exp[31:0]);
      poll(6);
      check("slot 6 value", polled_value, exp[32]);
      check("led_cout", polled_led, exp[32]);
   endtask

   //************************************************************
   // directed tests
   //************************************************************

   task automatic reset_values();
      for (int s = 1; s <= 6; s++)
      begin
         poll(s);
         check($sformatf("slot %0d value", s), polled_value, 0);
      end
      check("led_cout", led_cout, 0);
   endtask

   task automatic capture_and_hold();
      load(2'd0, 32'h1234_5678);
      load(2'd1, 32'h9abc_def0);
      // only bits 2:0 count for the opcode
      load(2'd2, 32'hffff_fff5);
      for (int pass = 0; pass < 2; pass++)
      begin
         poll(1);
         check("slot 1 value", polled_value, 32'h1234_5678);
         poll(2);
         check("slot 2 value", polled_value, 32'h9abc_def0);
         poll(3);
         check("slot 3 value", polled_value, 32'd5);
         // select 3 has no register
         load(2'd3, 32'hdead_beef);
      end
   endtask

   task automatic opcode_sweep();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      for (int op = 0; op < 8; op++)
      begin
         for (int n = 0; n < 20; n++)
         begin
            a      = next_rand();
            b      = next_rand();
            r      = next_rand();
            sw_cin = r[16];
            run_operation(op[2:0], a, b);
         end
      end
      sw_cin = 1'b0;
   endtask

   task automatic carry_in_cases();
      logic [31:0] edges [3];
      edges[0] = 32'hffff_ffff;
      edges[1] = 32'h0000_0000;
      edges[2] = 32'h0000_0001;
      for (int c = 0; c < 2; c++)
      begin
         sw_cin = c[0];
         poll(4);
         check("slot 4 value", polled_value, c);
         foreach (edges[i])
         begin
            foreach (edges[j])
            begin
               // add then sub on the same pair
               run_operation(3'd0, edges[i], edges[j]);
               run_operation(3'd1, edges[i], edges[j]);
            end
         end
      end
      sw_cin = 1'b0;
   endtask

   task automatic slot_range_sweep();
      logic in_range;
      for (int s = 0; s < 64; s++)
      begin
         in_range = (s >= 1) && (s <= 6);
         poll(s);
         check($sformatf("slot %0d display_valid", s), polled_valid, in_range);
         check($sformatf("slot %0d display_name", s), polled_name, slot_name(s));
         if (!in_range)
            check($sformatf("slot %0d display_value", s), polled_value, 0);
      end
   endtask

   //************************************************************
   // main sequence
   //************************************************************

   initial
   begin
      error_count    = 0;
      cycle_count    = 0;
      lcg_state      = 32'hf82a;
      resetn         = 1'b0;
      input_sel      = 2'd0;
      sw_cin         = 1'b0;
      input_valid    = 1'b0;
      input_value    = '0;
      display_number = '0;

      // reset low for 3 cycles
      repeat (3) @(negedge clk);
      resetn = 1'b1;

      reset_values();
      capture_and_hold();
      opcode_sweep();
      carry_in_cases();
      slot_range_sweep();

      $display("errors: %0d", error_count);
      if (error_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire
